// ==== flist.f ====
+incdir+tests
logic/pipe_pkg.sv
logic/de_stall_ctrl.sv
logic/dest_stage.sv
logic/hazard_scan.sv
logic/de_pipe_ctrl.sv
tests/tb_de_pipe_ctrl.sv

// ==== Bender.yml ====
package:
  name: de_pipe_ctrl

sources:
  # design
  - files:
      - logic/pipe_pkg.sv
      - logic/de_stall_ctrl.sv
      - logic/dest_stage.sv
      - logic/hazard_scan.sv
      - logic/de_pipe_ctrl.sv

  # testbench
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_de_pipe_ctrl.sv

// ==== tests/tb_checks.svh ====
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// all six decode status flags compared together
task automatic compare_status(input string name, input de_stall_t got, input de_stall_t exp);
  check_count++;
  if (got !== exp) begin
    err_count++;
    $display("** Error: row %0d %s got %h expected %h", cur_row, name, got, exp);
  end
endtask

task automatic compare_bit(input string name, input logic got, input logic exp);
  check_count++;
  if (got !== exp) begin
    err_count++;
    $display("** Error: row %0d %s got %h expected %h", cur_row, name, got, exp);
  end
endtask

task automatic compare_rec(input string name, input dest_rec_t got, input dest_rec_t exp);
  check_count++;
  if (got !== exp) begin
    err_count++;
    $display("** Error: row %0d %s got %h expected %h", cur_row, name, got, exp);
  end
endtask

// galois form for x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
  logic [31:0] n;
  n = s >> 1;
  if (s[0]) begin
    n = n ^ 32'h8020_0003;
  end
  return n;
endfunction

// msb first with one lfsr step per bit taken
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] r;
  r = '0;
  for (int i = 0; i < n; i++) begin
    lfsr_state = lfsr_step(lfsr_state);
    r = {r[30:0], lfsr_state[0]};
  end
  return r;
endfunction

// does this record write the repne counter in any slot
function automatic logic writes_ecx(input dest_rec_t rec);
  logic hit;
  hit = 1'b0;
  for (int d = 0; d < NUM_DEST; d++) begin
    if (rec.ld_reg[d] && rec.dreg[d] == REG_ECX) begin
      hit = 1'b1;
    end
  end
  return hit;
endfunction

`endif

// ==== tests/tb_de_pipe_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_de_pipe_ctrl;

  import pipe_pkg::*;

  localparam int MAX_ROWS = 128;
  localparam int N_RANDOM = 48;

  typedef struct packed {
    logic        v_de;
    de_op_t      op;
    logic [31:0] ecx;
    logic        zf;
    logic        stall_ag;
    logic        ag_dep_stall;
    logic        dc_exp;
    de_stall_t   exp_status;
    logic        exp_v_ag;
    logic        exp_ld_ag;
    logic        exp_ret_v;
    dest_rec_t   exp_ret_rec;
  } row_t;

  logic        clk;
  logic        rst;
  logic        v_de;
  de_op_t      de_op;
  logic [31:0] ecx;
  logic        zf;
  logic        stall_ag;
  logic        ag_dep_stall;
  logic        dc_exp;
  de_stall_t   status;
  logic        v_ag;
  logic        ld_ag;
  logic        retire_v;
  dest_rec_t   retire_rec;

  row_t        rows [MAX_ROWS];
  int          n_rows      = 0;
  int          cur_row     = 0;
  int          err_count   = 0;
  int          check_count = 0;
  int          cycle_cnt   = 0;
  int          cycle_limit = 0;
  int          n_accepted  = 0;
  int          n_retired   = 0;
  logic [31:0] lfsr_state;

  `include "tb_checks.svh"

  de_pipe_ctrl #(
    .NUM_STAGES (NUM_STAGES)
  ) de_pipe_ctrl_i (
    .clk          (clk),
    .rst          (rst),
    .v_de         (v_de),
    .de_op        (de_op),
    .ecx          (ecx),
    .zf           (zf),
    .stall_ag     (stall_ag),
    .ag_dep_stall (ag_dep_stall),
    .dc_exp       (dc_exp),
    .status       (status),
    .v_ag         (v_ag),
    .ld_ag        (ld_ag),
    .retire_v     (retire_v),
    .retire_rec   (retire_rec)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  function automatic dest_rec_t make_dest(input logic [2:0] ld_reg, input reg_idx_t r0,
                                          input reg_idx_t r1, input reg_idx_t r2,
                                          input logic ld_zf);
    dest_rec_t d;
    d.ld_reg  = ld_reg;
    d.dreg[0] = r0;
    d.dreg[1] = r1;
    d.dreg[2] = r2;
    d.ld_zf   = ld_zf;
    return d;
  endfunction

  function automatic de_op_t make_op(input logic repne, input logic hlt, input logic iret,
                                     input logic eip_change, input dest_rec_t dest);
    de_op_t op;
    op.repne      = repne;
    op.hlt        = hlt;
    op.iret       = iret;
    op.eip_change = eip_change;
    op.dest       = dest;
    return op;
  endfunction

  task automatic add_row(input logic v, input de_op_t op, input logic [31:0] ecx_v,
                         input logic zf_v, input logic sa, input logic ads, input logic dce);
    row_t r;
    r              = '0;
    r.v_de         = v;
    r.op           = op;
    r.ecx          = ecx_v;
    r.zf           = zf_v;
    r.stall_ag     = sa;
    r.ag_dep_stall = ads;
    r.dc_exp       = dce;
    rows[n_rows]   = r;
    n_rows++;
  endtask

  task automatic add_random_rows(input int count);
    de_op_t      op;
    logic        v;
    logic [31:0] ecx_r;
    logic        zf_r;
    logic        sa;
    logic        ads;
    logic        dce;
    for (int i = 0; i < count; i++) begin
      op             = '0;
      v              = rand_bits(1) != 0;
      op.repne       = rand_bits(2) == 0;
      op.hlt         = rand_bits(3) == 0;
      op.iret        = rand_bits(3) == 0;
      op.eip_change  = rand_bits(2) == 0;
      op.dest.ld_reg = 3'(rand_bits(3));
      op.dest.dreg   = 9'(rand_bits(9));
      op.dest.ld_zf  = rand_bits(2) == 0;
      ecx_r          = rand_bits(2); // small so zero shows up often
      zf_r           = rand_bits(2) == 0;
      sa             = rand_bits(2) == 0;
      ads            = rand_bits(3) == 0;
      dce            = rand_bits(3) == 0;
      add_row(v, op, ecx_r, zf_r, sa, ads, dce);
    end
  endtask

  task automatic build_table();
    dest_rec_t d_ecx;
    dest_rec_t d_zf;
    dest_rec_t d_a;
    dest_rec_t d_b;
    de_op_t    rep;
    d_ecx = make_dest(3'b010, 3'd0, REG_ECX, 3'd0, 1'b0);
    d_zf  = make_dest(3'b000, 3'd0, 3'd0, 3'd0, 1'b1);
    d_a   = make_dest(3'b001, 3'd2, 3'd0, 3'd0, 1'b0);
    d_b   = make_dest(3'b110, 3'd0, 3'd3, 3'd7, 1'b1);
    rep   = make_op(1'b1, 1'b0, 1'b0, 1'b0, '0);
    // branch, halt, iret flags
    add_row(1'b1, make_op(1'b0, 1'b0, 1'b0, 1'b1, d_a), 32'd7, 1'b0, 1'b0, 1'b0, 1'b0);
    add_row(1'b1, make_op(1'b0, 1'b1, 1'b0, 1'b0, d_b), 32'd7, 1'b0, 1'b0, 1'b0, 1'b0);
    add_row(1'b1, make_op(1'b0, 1'b0, 1'b1, 1'b0, d_a), 32'd7, 1'b0, 1'b0, 1'b0, 1'b0);
    add_row(1'b0, make_op(1'b0, 1'b1, 1'b1, 1'b1, d_b), 32'd7, 1'b0, 1'b0, 1'b0, 1'b0);
    // repne waits for the ecx write in flight
    add_row(1'b1, make_op(1'b0, 1'b0, 1'b0, 1'b0, d_ecx), 32'd3, 1'b0, 1'b0, 1'b0, 1'b0);
    repeat (6) add_row(1'b1, rep, 32'd3, 1'b0, 1'b0, 1'b0, 1'b0);
    add_row(1'b1, rep, 32'd0, 1'b0, 1'b0, 1'b0, 1'b0);  // count ran out
    add_row(1'b1, rep, 32'd0, 1'b0, 1'b0, 1'b0, 1'b0);  // zero on entry
    add_row(1'b1, rep, 32'h8000_0000, 1'b0, 1'b0, 1'b0, 1'b0); // only the top bit set
    add_row(1'b1, rep, 32'd2, 1'b1, 1'b0, 1'b0, 1'b0);  // zf match
    // zf write only matters once iterating
    add_row(1'b1, make_op(1'b0, 1'b0, 1'b0, 1'b0, d_zf), 32'd4, 1'b0, 1'b0, 1'b0, 1'b0);
    add_row(1'b1, rep, 32'd4, 1'b0, 1'b0, 1'b0, 1'b0);
    repeat (4) add_row(1'b1, rep, 32'd4, 1'b0, 1'b0, 1'b0, 1'b0);
    add_row(1'b1, rep, 32'd4, 1'b1, 1'b0, 1'b0, 1'b0);
    // back-pressure on ag
    add_row(1'b1, make_op(1'b0, 1'b0, 1'b0, 1'b0, d_a), 32'd5, 1'b0, 1'b0, 1'b0, 1'b0);
    add_row(1'b1, make_op(1'b0, 1'b0, 1'b0, 1'b0, d_b), 32'd5, 1'b0, 1'b1, 1'b0, 1'b0);
    add_row(1'b1, make_op(1'b0, 1'b0, 1'b0, 1'b0, d_b), 32'd5, 1'b0, 1'b1, 1'b0, 1'b0);
    add_row(1'b1, make_op(1'b0, 1'b0, 1'b0, 1'b0, d_b), 32'd5, 1'b0, 1'b0, 1'b1, 1'b0);
    add_row(1'b1, make_op(1'b0, 1'b0, 1'b0, 1'b0, d_b), 32'd5, 1'b0, 1'b0, 1'b0, 1'b0);
    // exception flush under stall
    add_row(1'b1, make_op(1'b0, 1'b0, 1'b0, 1'b0, d_zf), 32'd5, 1'b0, 1'b1, 1'b0, 1'b1);
    add_row(1'b0, '0, 32'd5, 1'b0, 1'b0, 1'b0, 1'b0);
    // back to back stream
    for (int i = 0; i < 5; i++) begin
      add_row(1'b1, make_op(1'b0, 1'b0, 1'b0, 1'b0,
                            make_dest(3'(i + 1), 3'(i + 2), 3'(i + 3), 3'(i + 4), i[0])),
              32'd9, 1'b0, 1'b0, 1'b0, 1'b0);
    end
    add_random_rows(N_RANDOM);
    repeat (NUM_STAGES + 2) add_row(1'b0, '0, 32'd0, 1'b0, 1'b0, 1'b0, 1'b0); // drain
  endtask

  // reference model that fills in the expected columns of every row
  task automatic build_expected();
    logic                  flag;
    logic                  flag_nxt;
    logic [NUM_STAGES-1:0] mv;
    dest_rec_t             mrec [NUM_STAGES];
    logic                  ecx_pend;
    logic                  zf_pend;
    logic                  ecx_nz;
    logic                  stop;
    logic                  dep;
    logic                  ld;
    logic                  vag;
    row_t                  r;
    flag = 1'b0;
    mv   = '0;
    for (int s = 0; s < NUM_STAGES; s++) begin
      mrec[s] = '0;
    end
    for (int i = 0; i < n_rows; i++) begin
      r        = rows[i];
      ecx_pend = 1'b0;
      zf_pend  = 1'b0;
      for (int s = 0; s < NUM_STAGES; s++) begin
        ecx_pend = ecx_pend | (mv[s] & writes_ecx(mrec[s]));
        zf_pend  = zf_pend | (mv[s] & mrec[s].ld_zf);
      end
      ecx_nz   = r.ecx != 32'd0;
      flag_nxt = flag ? (ecx_nz && !r.zf) : (ecx_nz && r.op.repne);
      stop     = flag ? (!ecx_nz || r.zf) : (r.op.repne && !ecx_nz);
      dep      = r.v_de && r.op.repne && (ecx_pend || (zf_pend && flag));
      ld       = !(r.stall_ag || r.ag_dep_stall) || r.dc_exp;
      vag      = r.v_de && !(r.op.hlt || r.op.iret || dep || stop || r.dc_exp);
      r.exp_status.hlt_stall   = r.v_de & r.op.hlt;
      r.exp_status.repne_stall = r.v_de & flag_nxt;
      r.exp_status.dep_stall   = dep;
      r.exp_status.br_stall    = r.v_de & r.op.eip_change;
      r.exp_status.iret_op     = r.v_de & r.op.iret;
      r.exp_status.stall_de    = r.stall_ag | r.ag_dep_stall;
      r.exp_v_ag    = vag;
      r.exp_ld_ag   = ld;
      r.exp_ret_v   = mv[NUM_STAGES-1];
      r.exp_ret_rec = mrec[NUM_STAGES-1];
      rows[i]       = r;
      for (int s = NUM_STAGES - 1; s > 0; s--) begin
        mv[s]   = (s == 1) ? (mv[0] & ld) : mv[s-1];
        mrec[s] = mrec[s-1];
      end
      if (ld) begin
        mv[0]   = vag;
        mrec[0] = r.op.dest;
      end
      if (ld && vag) begin
        n_accepted++;
      end
      flag = flag_nxt;
    end
  endtask

  task automatic drive_row(input row_t r);
    v_de         = r.v_de;
    de_op        = r.op;
    ecx          = r.ecx;
    zf           = r.zf;
    stall_ag     = r.stall_ag;
    ag_dep_stall = r.ag_dep_stall;
    dc_exp       = r.dc_exp;
  endtask

  task automatic check_row(input row_t r);
    compare_status("status", status, r.exp_status);
    compare_bit("v_ag", v_ag, r.exp_v_ag);
    compare_bit("ld_ag", ld_ag, r.exp_ld_ag);
    compare_bit("retire_v", retire_v, r.exp_ret_v);
    if (r.exp_ret_v) begin
      compare_rec("retire_rec", retire_rec, r.exp_ret_rec);
    end
  endtask

  initial begin
    rst          = 1'b1;
    v_de         = 1'b0;
    de_op        = '0;
    ecx          = '0;
    zf           = 1'b0;
    stall_ag     = 1'b0;
    ag_dep_stall = 1'b0;
    dc_exp       = 1'b0;
    lfsr_state   = 32'd92030;
    build_table();
    build_expected();
    cycle_limit = n_rows + NUM_STAGES + 20;
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    for (int i = 0; i < n_rows; i++) begin
      cur_row = i;
      drive_row(rows[i]);
      #2; // combinational outputs settled by mid cycle
      check_row(rows[i]);
      if (retire_v === 1'b1) begin
        n_retired++;
      end
      @(posedge clk);
      #1;
    end
    if (n_retired != n_accepted) begin
      err_count++;
      $display("** Error: retire count got %h expected %h", n_retired, n_accepted);
    end
    $display("checks: %0d  errors: %0d", check_count, err_count);
    if (err_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== logic/de_pipe_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module de_pipe_ctrl #(
  parameter int NUM_STAGES = pipe_pkg::NUM_STAGES
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                v_de,
  input  pipe_pkg::de_op_t    de_op,
  input  logic [31:0]         ecx,
  input  logic                zf,
  input  logic                stall_ag,
  input  logic                ag_dep_stall,
  input  logic                dc_exp,
  output pipe_pkg::de_stall_t status,
  output logic                v_ag,
  output logic                ld_ag,
  output logic                retire_v,
  output pipe_pkg::dest_rec_t retire_rec
);

  import pipe_pkg::*;

  dest_rec_t                   ag_rec;
  logic                        ecx_pending;
  logic                        zf_pending;
  logic [NUM_STAGES-1:0]       stage_v;
  dest_rec_t [NUM_STAGES-1:0]  stage_rec;

  de_stall_ctrl de_stall_ctrl_i (
    .clk          (clk),
    .rst          (rst),
    .v_de         (v_de),
    .de_op        (de_op),
    .ecx          (ecx),
    .zf           (zf),
    .ecx_pending  (ecx_pending),
    .zf_pending   (zf_pending),
    .stall_ag     (stall_ag),
    .ag_dep_stall (ag_dep_stall),
    .dc_exp       (dc_exp),
    .status       (status),
    .v_ag         (v_ag),
    .ld_ag        (ld_ag),
    .ag_rec       (ag_rec)
  );

  // stage 0 is ag, last stage is wb
  for (genvar k = 0; k < NUM_STAGES; k++) begin : g_stage
    logic      ld_k;
    logic      v_in_k;
    dest_rec_t rec_in_k;

    if (k == 0) begin : g_ag
      assign ld_k     = ld_ag;
      assign v_in_k   = v_ag;
      assign rec_in_k = ag_rec;
    end else begin : g_down
      assign ld_k     = 1'b1;
      // bubble behind ag while it holds
      assign v_in_k   = (k == 1) ? (stage_v[0] & ld_ag) : stage_v[k-1];
      assign rec_in_k = stage_rec[k-1];
    end

    dest_stage dest_stage_i (
      .clk     (clk),
      .rst     (rst),
      .ld      (ld_k),
      .v_in    (v_in_k),
      .rec_in  (rec_in_k),
      .v_out   (stage_v[k]),
      .rec_out (stage_rec[k])
    );
  end

  hazard_scan #(
    .NUM_STAGES (NUM_STAGES)
  ) hazard_scan_i (
    .stage_v     (stage_v),
    .stage_rec   (stage_rec),
    .ecx_pending (ecx_pending),
    .zf_pending  (zf_pending)
  );

  assign retire_v   = stage_v[NUM_STAGES-1];
  assign retire_rec = stage_rec[NUM_STAGES-1];

endmodule

`default_nettype wire

// ==== logic/hazard_scan.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazard_scan #(
  parameter int NUM_STAGES = pipe_pkg::NUM_STAGES
) (
  input  logic [NUM_STAGES-1:0]                stage_v,
  input  pipe_pkg::dest_rec_t [NUM_STAGES-1:0] stage_rec,
  output logic                                 ecx_pending,
  output logic                                 zf_pending
);

  import pipe_pkg::*;

  logic [NUM_STAGES-1:0] stage_ecx_hit;
  logic [NUM_STAGES-1:0] stage_zf_hit;

  // per stage match over all destination slots
  always_comb begin
    stage_ecx_hit = '0;
    stage_zf_hit  = '0;
    for (int s = 0; s < NUM_STAGES; s++) begin
      for (int d = 0; d < NUM_DEST; d++) begin
        if (stage_rec[s].ld_reg[d] && stage_rec[s].dreg[d] == REG_ECX) begin
          stage_ecx_hit[s] = stage_v[s];
        end
      end
      stage_zf_hit[s] = stage_v[s] & stage_rec[s].ld_zf;
    end
  end

  assign ecx_pending = |stage_ecx_hit;
  assign zf_pending  = |stage_zf_hit;  // qualified by the repne flag downstream

endmodule

`default_nettype wire

// ==== logic/dest_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module dest_stage (
  input  logic                clk,
  input  logic                rst,
  input  logic                ld,
  input  logic                v_in,
  input  pipe_pkg::dest_rec_t rec_in,
  output logic                v_out,
  output pipe_pkg::dest_rec_t rec_out
);

  logic                v_q;
  pipe_pkg::dest_rec_t rec_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      v_q <= 1'b0;
    end else if (ld) begin
      v_q <= v_in;
    end
  end

  // destination record travels with v_q
  always_ff @(posedge clk) begin
    if (ld) begin
      rec_q <= rec_in;
    end
  end

  assign v_out   = v_q;
  assign rec_out = rec_q;

endmodule

`default_nettype wire

// ==== logic/de_stall_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module de_stall_ctrl (
  input  logic                clk,
  input  logic                rst,
  input  logic                v_de,
  input  pipe_pkg::de_op_t    de_op,
  input  logic [31:0]         ecx,
  input  logic                zf,
  input  logic                ecx_pending,
  input  logic                zf_pending,
  input  logic                stall_ag,
  input  logic                ag_dep_stall,
  input  logic                dc_exp,
  output pipe_pkg::de_stall_t status,
  output logic                v_ag,
  output logic                ld_ag,
  output pipe_pkg::dest_rec_t ag_rec
);

  logic ecx_nz;
  logic repne_flag;      // set while a repne string op is iterating
  logic repne_flag_nxt;
  logic repne_stop;
  logic dep_stall;
  logic stall_de;
  logic kill_ag;

  assign ecx_nz = |ecx;

  // next value of the repeat flag
  always_comb begin
    if (repne_flag) begin
      repne_flag_nxt = ecx_nz & ~zf; // keep going until count or match
    end else begin
      repne_flag_nxt = ecx_nz & de_op.repne;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      repne_flag <= 1'b0;
    end else begin
      repne_flag <= repne_flag_nxt;
    end
  end

  // repeat ends with zero count on entry, or zero count / ZF during iteration
  always_comb begin
    repne_stop = 1'b0;
    if (!repne_flag) begin
      repne_stop = de_op.repne & ~ecx_nz;
    end else begin
      repne_stop = ~ecx_nz | zf;
    end
  end

  // repne reads ECX and also ZF once iterating
  always_comb begin
    dep_stall = 1'b0;
    if (v_de && de_op.repne) begin
      dep_stall = ecx_pending | (zf_pending & repne_flag);
    end
  end

  assign stall_de = stall_ag | ag_dep_stall;

  // exception flushes decode into ag regardless of stalls
  assign ld_ag = ~stall_de | dc_exp;

  assign kill_ag = de_op.hlt | de_op.iret | dep_stall | repne_stop | dc_exp;

  assign v_ag = v_de & ~kill_ag;

  assign ag_rec = de_op.dest; // record rides along with v_ag qualifying it

  always_comb begin
    status             = '0;
    status.hlt_stall   = v_de & de_op.hlt;
    status.repne_stall = v_de & repne_flag_nxt;
    status.dep_stall   = dep_stall;
    status.br_stall    = v_de & de_op.eip_change;
    status.iret_op     = v_de & de_op.iret;
    status.stall_de    = stall_de;
  end

endmodule

`default_nettype wire

// ==== logic/pipe_pkg.sv ====
`default_nettype none

package pipe_pkg;

  // downstream stages ag ro ex and wb after decode
  localparam int NUM_STAGES = 4;

  // destination slots per decoded op
  localparam int NUM_DEST = 3;

  // architectural register index
  typedef logic [2:0] reg_idx_t;

  // counter register for repne
  localparam reg_idx_t REG_ECX = 3'd1;

  // register and flag writes of one op in 13 bits
  typedef struct packed {
    logic [NUM_DEST-1:0]     ld_reg; // per-slot write enable
    reg_idx_t [NUM_DEST-1:0] dreg;   // per-slot destination
    logic                    ld_zf;  // op writes ZF
  } dest_rec_t;

  // decoded op flags coming into decode control
  typedef struct packed {
    logic      repne;
    logic      hlt;
    logic      iret;
    logic      eip_change;
    dest_rec_t dest;
  } de_op_t;

  // decode stage status
  typedef struct packed {
    logic hlt_stall;
    logic repne_stall;
    logic dep_stall;
    logic br_stall;
    logic iret_op;
    logic stall_de;
  } de_stall_t;

endpackage

`default_nettype wire
